/* include/addrgen_params.svh */
/*
 * Sizing macros of the vector address generator
 * Bus, address, vector length, burst and command queue dimensions
 */
`ifndef ADDRGEN_PARAMS_SVH
`define ADDRGEN_PARAMS_SVH

// Byte address width
`define ADDRGEN_ADDR_W 32

// Data bus width in bytes and its log2
`define ADDRGEN_BUS_BYTES 8
`define ADDRGEN_BUS_BYTES_LOG 3

// Vector length field width
`define ADDRGEN_VL_W 16

// Element and stride width
`define ADDRGEN_ELEN 64

// AXI4 burst limit in beats
`define ADDRGEN_MAX_BEATS 256

// 4 KiB page, no burst may cross it
`define ADDRGEN_PAGE_BITS 12

// Entries in the load/store command queue
`define ADDRGEN_CMD_DEPTH 2

`endif

/* hdl/addrgen_pkg.sv */
/*
 * Shared types of the vector address generator
 * Width typedefs, element width and operation enums
 * Sequencer request, work item, LSU command and AXI AR/AW structs
 */
`default_nettype none

`include "addrgen_params.svh"

package addrgen_pkg;

  // Widths that carry a meaning
  typedef logic [`ADDRGEN_ADDR_W-1:0]             addr_t;
  typedef logic [`ADDRGEN_VL_W-1:0]               vlen_t;
  typedef logic [`ADDRGEN_ELEN-1:0]               elen_t;
  // AXI len field, beats minus one
  typedef logic [$clog2(`ADDRGEN_MAX_BEATS)-1:0]  beat_len_t;
  // AXI size field, log2 of bytes per beat
  typedef logic [2:0]                             beat_size_t;

  // Element width, value is log2 of bytes
  typedef enum logic [1:0] {EW8, EW16, EW32, EW64} vew_e;

  // Unit-stride and strided loads/stores
  typedef enum logic [1:0] {VLE, VSE, VLSE, VSSE} vmem_op_e;

  // Operation from the sequencer
  typedef struct packed {
    vmem_op_e op;
    addr_t    addr;
    elen_t    stride;
    vlen_t    vl;
    vew_e     vew;
  } vmem_req_t;

  // Work item handed from accept stage to issuer
  typedef struct packed {
    addr_t addr;
    vlen_t len;
    elen_t stride;
    vew_e  vew;
    logic  is_load;
    logic  is_burst;
  } gen_req_t;

  // One issued request, as seen by the load/store units
  typedef struct packed {
    addr_t      addr;
    beat_len_t  len;
    beat_size_t size;
    logic       is_load;
  } lsu_cmd_t;

  // AR/AW payload, reduced to the fields in use
  typedef struct packed {
    addr_t      addr;
    beat_len_t  len;
    beat_size_t size;
    logic [1:0] burst;
    logic [3:0] cache;
  } axi_ax_t;

endpackage

`default_nettype wire

/* hdl/vmem_op_accept.sv */
/*
 * Accept stage for vector memory operations
 * Registers one sequencer request, checks element alignment
 * and holds the resulting work item until the issuer is done
 */
`timescale 1ns/100ps
`default_nettype none

module vmem_op_accept (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Sequencer
  input  addrgen_pkg::vmem_req_t req_i,
  input  logic                   req_valid_i,
  output logic                   req_ready_o,
  output logic                   ack_o,
  output logic                   error_o,
  // Issuer
  output addrgen_pkg::gen_req_t  gen_req_o,
  output logic                   gen_valid_o,
  input  logic                   gen_done_i
);

  typedef enum logic [1:0] {IDLE, CHECK, BUSY} state_e;

  state_e                 state_q, state_d;
  addrgen_pkg::vmem_req_t req_q;
  addrgen_pkg::addr_t     elem_mask;
  logic                   elem_misaligned;

  // Low address bits that must be zero for this element width
  assign elem_mask       = (addrgen_pkg::addr_t'(1) << req_q.vew) - addrgen_pkg::addr_t'(1);
  assign elem_misaligned = |(req_q.addr & elem_mask);

  // One operation at a time
  assign req_ready_o = (state_q == IDLE);
  assign gen_valid_o = (state_q == BUSY);

  // Error ack right after the check, plain ack on the issuer's last request
  assign error_o = (state_q == CHECK) && elem_misaligned;
  assign ack_o   = error_o || ((state_q == BUSY) && gen_done_i);

  // Work item view of the held request
  assign gen_req_o = '{
    addr:     req_q.addr,
    len:      req_q.vl,
    stride:   req_q.stride,
    vew:      req_q.vew,
    is_load:  req_q.op inside {addrgen_pkg::VLE, addrgen_pkg::VLSE},
    is_burst: req_q.op inside {addrgen_pkg::VLE, addrgen_pkg::VSE}
  };

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (req_valid_i) state_d = CHECK;
      // Misaligned operations end here
      CHECK:   state_d = elem_misaligned ? IDLE : BUSY;
      BUSY:    if (gen_done_i) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Request capture on handshake
  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_ready_o) begin
      req_q <= req_i;
    end
  end

  // Issuer only finishes work that was handed over
  a_done_in_busy : assert property (@(posedge clk_i) disable iff (!rst_ni)
    gen_done_i |-> state_q == BUSY);

endmodule

`default_nettype wire

/* hdl/burst_window.sv */
/*
 * Burst window calculator
 * Aligned end address of the next burst, capped at 256 beats and the page end
 * Narrowed beat size for stores that start off the bus word
 */
`timescale 1ns/100ps
`default_nettype none

`include "addrgen_params.svh"

module burst_window (
  input  addrgen_pkg::addr_t      addr_i,
  input  addrgen_pkg::vlen_t      len_i,
  input  addrgen_pkg::vew_e       vew_i,
  input  addrgen_pkg::beat_size_t size_log_i,
  output addrgen_pkg::addr_t      end_addr_o,
  output addrgen_pkg::beat_size_t narrow_size_o
);

  localparam int unsigned AW = `ADDRGEN_ADDR_W;
  localparam int unsigned PB = `ADDRGEN_PAGE_BITS;

  addrgen_pkg::addr_t req_bytes;
  addrgen_pkg::addr_t max_bytes;
  addrgen_pkg::addr_t span;
  addrgen_pkg::addr_t beat_mask;
  addrgen_pkg::addr_t last_beat;
  addrgen_pkg::addr_t win_end;

  //////////////////////////////////////////////////////////////////////
  // Narrow beat size

  // Trailing zeros of the offset in the bus word, lowest set bit wins
  always_comb begin
    narrow_size_o = addrgen_pkg::beat_size_t'(`ADDRGEN_BUS_BYTES_LOG);
    for (int i = `ADDRGEN_BUS_BYTES_LOG - 1; i >= 0; i--) begin
      if (addr_i[i]) narrow_size_o = addrgen_pkg::beat_size_t'(i);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // End address

  // Bytes still wanted versus the longest burst at this beat size
  assign req_bytes = addrgen_pkg::addr_t'(len_i) << vew_i;
  assign max_bytes = addrgen_pkg::addr_t'(`ADDRGEN_MAX_BEATS) << size_log_i;
  assign span      = (req_bytes < max_bytes) ? req_bytes : max_bytes;

  // Last byte, aligned down to its beat, then to the end of that beat
  assign beat_mask = (addrgen_pkg::addr_t'(1) << size_log_i) - addrgen_pkg::addr_t'(1);
  assign last_beat = (addr_i + span - addrgen_pkg::addr_t'(1)) & ~beat_mask;
  assign win_end   = last_beat + beat_mask;

  // Clip at the last byte of the start page
  assign end_addr_o = (win_end[AW-1:PB] == addr_i[AW-1:PB]) ? win_end :
                      {addr_i[AW-1:PB], {PB{1'b1}}};

endmodule

`default_nettype wire

/* hdl/axi_addr_issue.sv */
/*
 * AXI4 AR/AW request issuer
 * Walks a work item as INCR bursts or single-beat strided requests,
 * honours pending scalar stores and load/store ordering, pushes LSU commands
 */
`timescale 1ns/100ps
`default_nettype none

`include "addrgen_params.svh"

module axi_addr_issue (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // Accept stage
  input  addrgen_pkg::gen_req_t   gen_req_i,
  input  logic                    gen_valid_i,
  output logic                    gen_done_o,
  input  logic                    core_st_pending_i,
  // Burst window
  output addrgen_pkg::addr_t      win_addr_o,
  output addrgen_pkg::vlen_t      win_len_o,
  output addrgen_pkg::vew_e       win_vew_o,
  output addrgen_pkg::beat_size_t win_size_log_o,
  input  addrgen_pkg::addr_t      end_addr_i,
  input  addrgen_pkg::beat_size_t narrow_size_i,
  // Command queue status
  input  logic                    queue_full_i,
  input  logic                    queue_head_load_i,
  input  logic                    queue_empty_i,
  // AXI address channels
  output addrgen_pkg::axi_ax_t    ar_o,
  output logic                    ar_valid_o,
  input  logic                    ar_ready_i,
  output addrgen_pkg::axi_ax_t    aw_o,
  output logic                    aw_valid_o,
  input  logic                    aw_ready_i,
  // Command queue push
  output addrgen_pkg::lsu_cmd_t   cmd_o,
  output logic                    cmd_push_o
);

  localparam logic [1:0] BURST_INCR       = 2'b01;
  localparam logic [3:0] CACHE_MODIFIABLE = 4'b0010;
  localparam addrgen_pkg::beat_size_t FULL_SIZE =
    addrgen_pkg::beat_size_t'(`ADDRGEN_BUS_BYTES_LOG);

  typedef enum logic [1:0] {IDLE, MISALIGN, WAIT, REQUEST} state_e;

  state_e                  state_q, state_d;
  addrgen_pkg::gen_req_t   cur_q, cur_d;
  addrgen_pkg::addr_t      end_q, end_d;
  addrgen_pkg::beat_size_t size_log_q, size_log_d;

  addrgen_pkg::addr_t      beat_mask;
  addrgen_pkg::addr_t      start_aligned;
  addrgen_pkg::addr_t      used_elems;
  addrgen_pkg::axi_ax_t    ax;
  logic                    misaligned_st;
  logic                    order_ok;
  logic                    issue;
  logic                    xfer;
  logic                    load_end;

  //////////////////////////////////////////////////////////////////////
  // Request payload

  assign beat_mask     = (addrgen_pkg::addr_t'(1) << size_log_q) - addrgen_pkg::addr_t'(1);
  assign start_aligned = cur_q.addr & ~beat_mask;
  // Elements covered up to the window end
  assign used_elems    = (end_q - cur_q.addr + addrgen_pkg::addr_t'(1)) >> cur_q.vew;

  always_comb begin
    ax.addr  = cur_q.addr;
    ax.burst = BURST_INCR;
    ax.cache = CACHE_MODIFIABLE;
    if (cur_q.is_burst) begin
      // Beats from the aligned start to the window end
      ax.len  = addrgen_pkg::beat_len_t'((end_q - start_aligned) >> size_log_q);
      ax.size = size_log_q;
    end else begin
      // One element per strided request
      ax.len  = '0;
      ax.size = addrgen_pkg::beat_size_t'(cur_q.vew);
    end
  end

  assign ar_o  = ax;
  assign aw_o  = ax;
  assign cmd_o = '{addr: ax.addr, len: ax.len, size: ax.size, is_load: cur_q.is_load};

  //////////////////////////////////////////////////////////////////////
  // Handshake

  // Queue holds one direction only, wait for it to drain before switching
  assign order_ok   = queue_empty_i || (queue_head_load_i == cur_q.is_load);
  assign issue      = (state_q == REQUEST) && !queue_full_i && order_ok;
  assign ar_valid_o = issue && cur_q.is_load;
  assign aw_valid_o = issue && !cur_q.is_load;
  assign xfer       = (ar_valid_o && ar_ready_i) || (aw_valid_o && aw_ready_i);
  assign cmd_push_o = xfer;

  //////////////////////////////////////////////////////////////////////
  // Operation walk

  // Unit-stride store starting inside a bus word
  assign misaligned_st = gen_req_i.is_burst && !gen_req_i.is_load &&
    ((gen_req_i.addr & addrgen_pkg::addr_t'(`ADDRGEN_BUS_BYTES - 1)) != '0);

  always_comb begin
    state_d    = state_q;
    cur_d      = cur_q;
    gen_done_o = 1'b0;
    case (state_q)
      IDLE: begin
        if (gen_valid_i) begin
          cur_d = gen_req_i;
          if (misaligned_st) begin
            state_d = MISALIGN;
          end else begin
            state_d = core_st_pending_i ? WAIT : REQUEST;
          end
        end
      end
      // Window is redone here with the narrowed size
      MISALIGN: state_d = core_st_pending_i ? WAIT : REQUEST;
      WAIT:     if (!core_st_pending_i) state_d = REQUEST;
      REQUEST: begin
        if (xfer) begin
          if (cur_q.is_burst) begin
            // Floor at zero when the window ran past the last element
            if (addrgen_pkg::addr_t'(cur_q.len) <= used_elems) begin
              cur_d.len = '0;
            end else begin
              cur_d.len = cur_q.len - addrgen_pkg::vlen_t'(used_elems);
            end
            cur_d.addr = end_q + addrgen_pkg::addr_t'(1);
          end else begin
            cur_d.len  = cur_q.len - addrgen_pkg::vlen_t'(1);
            cur_d.addr = cur_q.addr + addrgen_pkg::addr_t'(cur_q.stride);
          end
          if (cur_d.len == '0) begin
            gen_done_o = 1'b1;
            state_d    = IDLE;
          end
        end
      end
      default: state_d = IDLE;
    endcase
  end

  // Beat size picked when an operation starts
  assign size_log_d = (state_q == IDLE && gen_valid_i) ?
                      (misaligned_st ? narrow_size_i : FULL_SIZE) : size_log_q;

  // Window tracks the next address, full bus size until narrowed
  assign win_addr_o     = cur_d.addr;
  assign win_len_o      = cur_d.len;
  assign win_vew_o      = cur_d.vew;
  assign win_size_log_o = (state_q == IDLE) ? FULL_SIZE : size_log_q;

  assign load_end = (state_q == IDLE && gen_valid_i) || (state_q == MISALIGN) || xfer;
  assign end_d    = load_end ? end_addr_i : end_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    cur_q      <= cur_d;
    end_q      <= end_d;
    size_log_q <= size_log_d;
  end

  //////////////////////////////////////////////////////////////////////
  // Checks

  // Burst window never runs past the start address's page
  a_burst_in_page : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (ar_valid_o || aw_valid_o) && cur_q.is_burst |->
      end_q[`ADDRGEN_ADDR_W-1:`ADDRGEN_PAGE_BITS] ==
      cur_q.addr[`ADDRGEN_ADDR_W-1:`ADDRGEN_PAGE_BITS]);

  // Held request keeps valid and payload across stalls
  a_ar_stable : assert property (@(posedge clk_i) disable iff (!rst_ni)
    ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_o));
  a_aw_stable : assert property (@(posedge clk_i) disable iff (!rst_ni)
    aw_valid_o && !aw_ready_i |=> aw_valid_o && $stable(aw_o));

endmodule

`default_nettype wire

/* hdl/lsu_cmd_fifo.sv */
/*
 * Command queue toward the load/store units
 * Circular buffer with occupancy count, exports head direction
 */
`timescale 1ns/100ps
`default_nettype none

`include "addrgen_params.svh"

module lsu_cmd_fifo (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Issuer side
  input  addrgen_pkg::lsu_cmd_t cmd_i,
  input  logic                  push_i,
  output logic                  full_o,
  output logic                  empty_o,
  output logic                  head_load_o,
  // Load/store unit side
  output addrgen_pkg::lsu_cmd_t cmd_o,
  output logic                  valid_o,
  input  logic                  ready_i
);

  localparam int unsigned DEPTH = `ADDRGEN_CMD_DEPTH;
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  addrgen_pkg::lsu_cmd_t mem_q [DEPTH];
  logic [PTR_W-1:0]      wr_ptr_q;
  logic [PTR_W-1:0]      rd_ptr_q;
  logic [PTR_W:0]        count_q;
  logic                  pop;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full_o      = (count_q == (PTR_W + 1)'(DEPTH));
  assign empty_o     = (count_q == '0);
  assign valid_o     = !empty_o;
  assign pop         = valid_o && ready_i;
  assign cmd_o       = mem_q[rd_ptr_q];
  // Direction for the load/store ordering rule
  assign head_load_o = mem_q[rd_ptr_q].is_load;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (pop) rd_ptr_q <= ptr_inc(rd_ptr_q);
      case ({push_i, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= cmd_i;
    end
  end

  // Issuer keeps its valid low while the queue is full
  a_no_push_full : assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i |-> !full_o);

endmodule

`default_nettype wire

/* hdl/addrgen_top.sv */
/*
 * Vector memory address generator, top level
 * Accept stage, AXI address issuer, burst window and LSU command queue
 */
`timescale 1ns/100ps
`default_nettype none

module addrgen_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Sequencer
  input  addrgen_pkg::vmem_req_t req_i,
  input  logic                   req_valid_i,
  output logic                   req_ready_o,
  output logic                   ack_o,
  output logic                   error_o,
  // Core
  input  logic                   core_st_pending_i,
  // AXI AR/AW
  output addrgen_pkg::axi_ax_t   ar_o,
  output logic                   ar_valid_o,
  input  logic                   ar_ready_i,
  output addrgen_pkg::axi_ax_t   aw_o,
  output logic                   aw_valid_o,
  input  logic                   aw_ready_i,
  // Load/store units
  output addrgen_pkg::lsu_cmd_t  lsu_cmd_o,
  output logic                   lsu_cmd_valid_o,
  input  logic                   lsu_cmd_ready_i
);

  // Accept to issuer
  addrgen_pkg::gen_req_t   gen_req;
  logic                    gen_valid;
  logic                    gen_done;

  // Issuer to window
  addrgen_pkg::addr_t      win_addr;
  addrgen_pkg::vlen_t      win_len;
  addrgen_pkg::vew_e       win_vew;
  addrgen_pkg::beat_size_t win_size_log;
  addrgen_pkg::addr_t      end_addr;
  addrgen_pkg::beat_size_t narrow_size;

  // Issuer to queue
  addrgen_pkg::lsu_cmd_t   cmd;
  logic                    cmd_push;
  logic                    queue_full;
  logic                    queue_empty;
  logic                    queue_head_load;

  vmem_op_accept u_accept (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_i       (req_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .ack_o       (ack_o),
    .error_o     (error_o),
    .gen_req_o   (gen_req),
    .gen_valid_o (gen_valid),
    .gen_done_i  (gen_done)
  );

  axi_addr_issue u_issue (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .gen_req_i         (gen_req),
    .gen_valid_i       (gen_valid),
    .gen_done_o        (gen_done),
    .core_st_pending_i (core_st_pending_i),
    .win_addr_o        (win_addr),
    .win_len_o         (win_len),
    .win_vew_o         (win_vew),
    .win_size_log_o    (win_size_log),
    .end_addr_i        (end_addr),
    .narrow_size_i     (narrow_size),
    .queue_full_i      (queue_full),
    .queue_head_load_i (queue_head_load),
    .queue_empty_i     (queue_empty),
    .ar_o              (ar_o),
    .ar_valid_o        (ar_valid_o),
    .ar_ready_i        (ar_ready_i),
    .aw_o              (aw_o),
    .aw_valid_o        (aw_valid_o),
    .aw_ready_i        (aw_ready_i),
    .cmd_o             (cmd),
    .cmd_push_o        (cmd_push)
  );

  burst_window u_window (
    .addr_i        (win_addr),
    .len_i         (win_len),
    .vew_i         (win_vew),
    .size_log_i    (win_size_log),
    .end_addr_o    (end_addr),
    .narrow_size_o (narrow_size)
  );

  lsu_cmd_fifo u_cmd_fifo (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cmd_i       (cmd),
    .push_i      (cmd_push),
    .full_o      (queue_full),
    .empty_o     (queue_empty),
    .head_load_o (queue_head_load),
    .cmd_o       (lsu_cmd_o),
    .valid_o     (lsu_cmd_valid_o),
    .ready_i     (lsu_cmd_ready_i)
  );

endmodule

`default_nettype wire

/* verification/addrgen_tb.sv */
/*
 * Testbench of the vector address generator
 * Operations and expected requests from a stimulus file, random AXI and LSU ready,
 * transfer and command monitor, ordering and stability checks, watchdog
 */
`timescale 1ns/100ps
`default_nettype none

`include "addrgen_params.svh"

module addrgen_tb;

  localparam int unsigned STIM_WORDS  = 512;
  localparam int unsigned REC_WORDS   = 8;
  localparam int unsigned OP_CYCLES   = 2000;
  localparam int unsigned PEND_CYCLES = 12;

  logic                   clk_i;
  logic                   rst_ni;
  addrgen_pkg::vmem_req_t req_i;
  logic                   req_valid_i;
  logic                   req_ready_o;
  logic                   ack_o;
  logic                   error_o;
  logic                   core_st_pending_i;
  addrgen_pkg::axi_ax_t   ar_o;
  logic                   ar_valid_o;
  logic                   ar_ready_i;
  addrgen_pkg::axi_ax_t   aw_o;
  logic                   aw_valid_o;
  logic                   aw_ready_i;
  addrgen_pkg::lsu_cmd_t  lsu_cmd_o;
  logic                   lsu_cmd_valid_o;
  logic                   lsu_cmd_ready_i;

  // Records of 8 words, first word is the kind
  logic [63:0]            stim_mem [STIM_WORDS];
  int unsigned            num_ops;
  int unsigned            num_checks;
  int unsigned            num_errors;

  // Expected requests, one list per observation point
  addrgen_pkg::lsu_cmd_t  exp_ax [$];
  addrgen_pkg::lsu_cmd_t  exp_cmd [$];
  // Direction of each command the DUT queue should hold, 1 for load
  logic                   dir_q [$];

  // Stalled request seen at the previous edge
  logic                   ar_hold;
  logic                   aw_hold;
  addrgen_pkg::axi_ax_t   ar_held;
  addrgen_pkg::axi_ax_t   aw_held;

  addrgen_top UUT (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .req_i             (req_i),
    .req_valid_i       (req_valid_i),
    .req_ready_o       (req_ready_o),
    .ack_o             (ack_o),
    .error_o           (error_o),
    .core_st_pending_i (core_st_pending_i),
    .ar_o              (ar_o),
    .ar_valid_o        (ar_valid_o),
    .ar_ready_i        (ar_ready_i),
    .aw_o              (aw_o),
    .aw_valid_o        (aw_valid_o),
    .aw_ready_i        (aw_ready_i),
    .lsu_cmd_o         (lsu_cmd_o),
    .lsu_cmd_valid_o   (lsu_cmd_valid_o),
    .lsu_cmd_ready_i   (lsu_cmd_ready_i)
  );

  // 8 ns period
  always #4 clk_i = ~clk_i;

  //////////////////////////////////////////////////////////////////////
  // Check helpers

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] expected);
    num_checks++;
    if (got !== expected) begin
      num_errors++;
      $display("Fail %0t ns: %s got 0x%0h, expected 0x%0h", $time, name, got, expected);
    end
  endtask

  task automatic report_error(input string msg);
    num_errors++;
    $display("Error at %0t ns: %s", $time, msg);
  endtask

  function automatic logic dir_queued(input logic is_load);
    foreach (dir_q[i]) begin
      if (dir_q[i] == is_load) return 1'b1;
    end
    return 1'b0;
  endfunction

  // One AR or AW transfer against the next expected request
  task automatic check_transfer(input addrgen_pkg::axi_ax_t ax, input logic is_load,
                                input string name);
    addrgen_pkg::lsu_cmd_t expected;
    if (exp_ax.size() == 0) begin
      report_error({name, " transfer with no request expected"});
    end else begin
      expected = exp_ax.pop_front();
      check_value({name, ".addr"}, 64'(ax.addr), 64'(expected.addr));
      check_value({name, ".len"}, 64'(ax.len), 64'(expected.len));
      check_value({name, ".size"}, 64'(ax.size), 64'(expected.size));
      // INCR burst, modifiable cache
      check_value({name, ".burst"}, 64'(ax.burst), 64'd1);
      check_value({name, ".cache"}, 64'(ax.cache), 64'd2);
      check_value({name, " channel is_load"}, 64'(is_load), 64'(expected.is_load));
    end
  endtask

  task automatic check_pop(input addrgen_pkg::lsu_cmd_t cmd);
    addrgen_pkg::lsu_cmd_t expected;
    if (exp_cmd.size() == 0) begin
      report_error("Command popped with none expected");
    end else begin
      expected = exp_cmd.pop_front();
      check_value("lsu_cmd_o.addr", 64'(cmd.addr), 64'(expected.addr));
      check_value("lsu_cmd_o.len", 64'(cmd.len), 64'(expected.len));
      check_value("lsu_cmd_o.size", 64'(cmd.size), 64'(expected.size));
      check_value("lsu_cmd_o.is_load", 64'(cmd.is_load), 64'(expected.is_load));
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus

  // Random back-pressure on all three consumers
  always @(negedge clk_i) begin
    ar_ready_i      = ($urandom % 4) != 0;
    aw_ready_i      = ($urandom % 3) != 0;
    lsu_cmd_ready_i = ($urandom % 2) != 0;
  end

  // One operation record from the sequencer, then wait for its ack
  task automatic run_op(input int unsigned base);
    logic exp_err;
    logic pend;
    exp_err = stim_mem[base + 6][0];
    pend    = stim_mem[base + 7][0];
    @(negedge clk_i);
    req_i.op          = addrgen_pkg::vmem_op_e'(stim_mem[base + 1][1:0]);
    req_i.addr        = addrgen_pkg::addr_t'(stim_mem[base + 2]);
    req_i.stride      = stim_mem[base + 3];
    req_i.vl          = addrgen_pkg::vlen_t'(stim_mem[base + 4]);
    req_i.vew         = addrgen_pkg::vew_e'(stim_mem[base + 5][1:0]);
    req_valid_i       = 1'b1;
    core_st_pending_i = pend;
    while (!req_ready_o) @(negedge clk_i);
    // Taken at the edge in between
    @(negedge clk_i);
    req_valid_i = 1'b0;
    if (pend) begin
      repeat (PEND_CYCLES) @(negedge clk_i);
      core_st_pending_i = 1'b0;
    end
    @(posedge clk_i);
    while (!ack_o) @(posedge clk_i);
    check_value("error_o", 64'(error_o), 64'(exp_err));
    // Last request issues in the ack cycle, the monitor has taken it by now
    @(negedge clk_i);
    check_value("requests left after ack_o", 64'(exp_ax.size()), 64'd0);
    @(posedge clk_i);
    check_value("ack_o", 64'(ack_o), 64'd0);
  endtask

  initial begin
    int unsigned           pos;
    addrgen_pkg::lsu_cmd_t expected;
    void'($urandom(32'h02a7_cd7a));
    clk_i             = 1'b0;
    rst_ni            = 1'b0;
    req_i             = '0;
    req_valid_i       = 1'b0;
    core_st_pending_i = 1'b0;
    ar_ready_i        = 1'b0;
    aw_ready_i        = 1'b0;
    lsu_cmd_ready_i   = 1'b0;
    ar_hold           = 1'b0;
    aw_hold           = 1'b0;
    num_checks        = 0;
    num_errors        = 0;
    $readmemh("verification/addrgen_stim.txt", stim_mem);

    // Operation count sets the watchdog limit
    pos = 0;
    while (pos < STIM_WORDS && (stim_mem[pos] === 64'h1 || stim_mem[pos] === 64'h2)) begin
      if (stim_mem[pos] === 64'h1) num_ops++;
      pos += REC_WORDS;
    end
    if (num_ops == 0) report_error("No operations found in the stimulus file");

    repeat (3) @(posedge clk_i);
    // Idle outputs while in reset
    check_value("req_ready_o", 64'(req_ready_o), 64'd1);
    check_value("ack_o", 64'(ack_o), 64'd0);
    check_value("error_o", 64'(error_o), 64'd0);
    check_value("ar_valid_o", 64'(ar_valid_o), 64'd0);
    check_value("aw_valid_o", 64'(aw_valid_o), 64'd0);
    check_value("lsu_cmd_valid_o", 64'(lsu_cmd_valid_o), 64'd0);
    @(negedge clk_i);
    rst_ni = 1'b1;

    pos = 0;
    while (pos < STIM_WORDS && stim_mem[pos] === 64'h1) begin
      // Requests listed right after their operation
      for (int unsigned r = pos + REC_WORDS;
           r < STIM_WORDS && stim_mem[r] === 64'h2; r += REC_WORDS) begin
        expected.addr    = addrgen_pkg::addr_t'(stim_mem[r + 1]);
        expected.len     = addrgen_pkg::beat_len_t'(stim_mem[r + 2]);
        expected.size    = addrgen_pkg::beat_size_t'(stim_mem[r + 3]);
        expected.is_load = stim_mem[r + 4][0];
        exp_ax.push_back(expected);
        exp_cmd.push_back(expected);
      end
      run_op(pos);
      pos += REC_WORDS;
      while (pos < STIM_WORDS && stim_mem[pos] === 64'h2) pos += REC_WORDS;
    end

    // Let the command queue drain
    while (exp_ax.size() != 0 || exp_cmd.size() != 0) @(posedge clk_i);
    repeat (4) @(posedge clk_i);
    $display("Checks run: %0d, errors: %0d", num_checks, num_errors);
    if (num_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // Monitor

  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (core_st_pending_i && (ar_valid_o || aw_valid_o)) begin
        report_error("Request valid while a scalar store was pending");
      end
      // No switch of direction while the queue holds the other kind
      if (ar_valid_o && dir_queued(1'b0)) report_error("AR valid with stores still queued");
      if (aw_valid_o && dir_queued(1'b1)) report_error("AW valid with loads still queued");
      if ((ar_valid_o || aw_valid_o) && dir_q.size() >= `ADDRGEN_CMD_DEPTH) begin
        report_error("Request valid with the command queue full");
      end
      check_value("lsu_cmd_valid_o", 64'(lsu_cmd_valid_o), 64'(dir_q.size() != 0));

      // Stalled requests hold valid and payload
      if (ar_hold) begin
        check_value("ar_valid_o held", 64'(ar_valid_o), 64'd1);
        check_value("ar_o held", 64'(ar_o), 64'(ar_held));
      end
      if (aw_hold) begin
        check_value("aw_valid_o held", 64'(aw_valid_o), 64'd1);
        check_value("aw_o held", 64'(aw_o), 64'(aw_held));
      end
      ar_hold = ar_valid_o && !ar_ready_i;
      aw_hold = aw_valid_o && !aw_ready_i;
      ar_held = ar_o;
      aw_held = aw_o;

      if (lsu_cmd_valid_o && lsu_cmd_ready_i) begin
        check_pop(lsu_cmd_o);
        if (dir_q.size() != 0) dir_q.delete(0);
      end
      if (ar_valid_o && ar_ready_i) begin
        check_transfer(ar_o, 1'b1, "ar_o");
        dir_q.push_back(1'b1);
      end
      if (aw_valid_o && aw_ready_i) begin
        check_transfer(aw_o, 1'b0, "aw_o");
        dir_q.push_back(1'b0);
      end
    end
  end

  // Ends a stuck run
  initial begin
    wait (num_ops != 0);
    repeat (num_ops * OP_CYCLES) @(posedge clk_i);
    $display("Timeout after %0d cycles, the operations did not finish", num_ops * OP_CYCLES);
    $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire

/* verification/addrgen_stim.txt */
// Kind 1, operation: 1 op addr stride vl vew exp_error st_pending (op VLE=0 VSE=1 VLSE=2 VSSE=3)
// Kind 2, expected request: 2 addr len size is_load 0 0 0; kind 0 ends the list
// Unit-stride load, one burst
1 0 10000100 0 20 3 0 0
2 10000100 1f 3 1 0 0 0
// Load crossing a 4 KiB page
1 0 00000f80 0 40 2 0 0
2 00000f80 0f 3 1 0 0 0
2 00001000 0f 3 1 0 0 0
// Load longer than 256 beats
1 0 00002000 0 12c 3 0 0
2 00002000 ff 3 1 0 0 0
2 00002800 2b 3 1 0 0 0
// Strided store, stride 24
1 3 00003000 18 4 2 0 0
2 00003000 0 2 0 0 0 0
2 00003018 0 2 0 0 0 0
2 00003030 0 2 0 0 0 0
2 00003048 0 2 0 0 0 0
// Stores starting inside the bus word
1 1 00004004 0 8 2 0 0
2 00004004 7 2 0 0 0 0
1 1 00005006 0 5 1 0 0
2 00005006 4 1 0 0 0 0
// EW32 at offset 2
1 0 00006002 0 4 2 1 0
// Load behind a pending scalar store, then a store
1 0 00007000 0 10 0 0 1
2 00007000 1 3 1 0 0 0
1 1 00008000 0 4 3 0 0
2 00008000 3 3 0 0 0 0
// Strided load, stride -8
1 2 00009000 fffffffffffffff8 3 3 0 0
2 00009000 0 3 1 0 0 0
2 00008ff8 0 3 1 0 0 0
2 00008ff0 0 3 1 0 0 0
0 0 0 0 0 0 0 0

/* addrgen_top.f */
+incdir+include
hdl/addrgen_pkg.sv
hdl/vmem_op_accept.sv
hdl/burst_window.sv
hdl/axi_addr_issue.sv
hdl/lsu_cmd_fifo.sv
hdl/addrgen_top.sv
verification/addrgen_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the address generator testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
  -f addrgen_top.f --top-module addrgen_tb -o addrgen_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/addrgen_sim)
sim_status=$?
printf '%s\n' "$sim_out"

if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "All checks passed"; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed"
  exit 1
fi
